//--- src/cnn_ctrl_config.svh
`ifndef CNN_CTRL_CONFIG_SVH
`define CNN_CTRL_CONFIG_SVH

// 32-bit words per layer command
`define CNN_CMD_WORDS 6

// Command FIFO entries, kept to a power of two
`define CNN_FIFO_DEPTH 16

// Memory address width for data, weight and write-back
`define CNN_ADDR_W 32

`endif

//--- src/cnn_cmd_pkg.sv
package cnn_cmd_pkg;

    // Layer operation codes, 6 and 7 unused
    typedef enum logic [2:0] {
        op_idle        = 3'd0,
        op_conv1x1     = 3'd1,
        op_conv3x3     = 3'd2,
        op_conv3x3_pad = 3'd3,
        op_maxpool3    = 3'd4,
        op_avepool13   = 3'd5
    } op_e;

    // Six command words, word 5 in the top bits and word 0 at the bottom
    typedef struct packed {
        // Word 5
        logic [31:0] wb_addr;
        // Word 4
        logic [31:0] data_addr;
        // Word 3
        logic [31:0] wt_addr;
        // Word 2, output kernel size on top
        logic [15:0] okn_size;
        logic [15:0] ikn_size;
        // Word 1, output channel count on top
        logic [15:0] och_size;
        logic [15:0] ich_size;
        // Word 0, surface stride up to 224*224
        logic [15:0] surf_stride;
        // Line stride up to 224
        logic [7:0]  line_stride;
        // Spare bits 7:4 of word 0
        logic [3:0]  rsvd;
        logic        padding;
        op_e         op;
    } layer_desc_t;

endpackage

//--- src/cnn_ctrl_pkg.sv
package cnn_ctrl_pkg;

    // Sequencer states
    typedef enum logic [2:0] {
        // Waiting for op_en
        st_idle,
        // Pulling one command through the parser
        st_collect,
        // Decode and address setup
        st_issue,
        // Engine busy until its valid
        st_wait,
        // FIFO drained, irq held
        st_finish
    } seq_state_e;

    // One-hot engine select, all zero when nothing runs
    typedef struct packed {
        logic conv;
        logic maxpool;
        logic avepool;
    } engine_sel_t;

endpackage

//--- src/cmd_fifo.sv
`timescale 1ns/1ps
`include "cnn_ctrl_config.svh"

module cmd_fifo (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        wr,
    input  logic [31:0] wdata,
    input  logic        rd_en,
    output logic [31:0] head,
    output logic        empty,
    output logic        full
);

    localparam int AW = $clog2(`CNN_FIFO_DEPTH);

    // Storage, no reset needed
    logic [31:0] mem [`CNN_FIFO_DEPTH];

    // Extra MSB tells full from empty
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;

    logic do_wr;
    logic do_rd;

    // Writes into a full FIFO are lost
    assign do_wr = wr && !full;
    assign do_rd = rd_en && !empty;

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr[AW-1:0]] <= wdata;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            // Pointers move independently, so read plus write keeps the count
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // First word falls through
    assign head  = mem[rd_ptr[AW-1:0]];
    assign empty = (wr_ptr == rd_ptr);
    // Same index, wrapped once
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

endmodule

//--- src/cmd_parser.sv
`timescale 1ns/1ps
`include "cnn_ctrl_config.svh"

module cmd_parser (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     fetch_req,
    input  logic [31:0]              fifo_head,
    input  logic                     fifo_empty,
    output logic                     fifo_rd_en,
    output cnn_cmd_pkg::layer_desc_t desc,
    output logic                     desc_done
);

    localparam int CNT_W = $clog2(`CNN_CMD_WORDS + 1);

    // Words popped so far for this command
    logic [CNT_W-1:0] cnt;
    logic             last_pop;

    // Pop while requested, data present and command incomplete
    assign fifo_rd_en = fetch_req && !fifo_empty && (cnt < CNT_W'(`CNN_CMD_WORDS));
    assign last_pop   = fifo_rd_en && (cnt == CNT_W'(`CNN_CMD_WORDS - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt       <= '0;
            desc_done <= 1'b0;
        end else if (!fetch_req) begin
            // Fresh count for every fetch
            cnt       <= '0;
            desc_done <= 1'b0;
        end else begin
            if (fifo_rd_en) begin
                cnt <= cnt + 1'b1;
            end
            // Pulse one cycle after the sixth word
            desc_done <= last_pop;
        end
    end

    // Field fill by word index, held until the next fetch
    always_ff @(posedge clk) begin
        if (fifo_rd_en) begin
            case (int'(cnt))
                0: begin
                    desc.op          <= cnn_cmd_pkg::op_e'(fifo_head[2:0]);
                    desc.padding     <= fifo_head[3];
                    desc.rsvd        <= fifo_head[7:4];
                    desc.line_stride <= fifo_head[15:8];
                    desc.surf_stride <= fifo_head[31:16];
                end
                1: begin
                    desc.ich_size <= fifo_head[15:0];
                    desc.och_size <= fifo_head[31:16];
                end
                2: begin
                    desc.ikn_size <= fifo_head[15:0];
                    desc.okn_size <= fifo_head[31:16];
                end
                3: begin
                    desc.wt_addr <= fifo_head;
                end
                4: begin
                    desc.data_addr <= fifo_head;
                end
                5: begin
                    desc.wb_addr <= fifo_head;
                end
                default: begin
                end
            endcase
        end
    end

endmodule

//--- src/op_dispatcher.sv
`timescale 1ns/1ps
`include "cnn_ctrl_config.svh"

module op_dispatcher (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     op_en,
    input  cnn_cmd_pkg::layer_desc_t desc,
    input  logic                     desc_done,
    input  logic                     fifo_empty,
    output logic                     fetch_req,
    input  logic                     conv_valid,
    input  logic                     maxpool_valid,
    input  logic                     avepool_valid,
    output logic                     conv_ready,
    output logic                     maxpool_ready,
    output logic                     avepool_ready,
    output logic                     data_rd_en,
    output logic                     weight_rd_en,
    output logic [`CNN_ADDR_W-1:0]   r_addr,
    output logic [`CNN_ADDR_W-1:0]   w_addr,
    output logic [`CNN_ADDR_W-1:0]   wt_addr,
    output cnn_cmd_pkg::op_e         op_type,
    output logic                     irq
);

    cnn_ctrl_pkg::seq_state_e  state;
    cnn_ctrl_pkg::seq_state_e  state_nxt;
    cnn_ctrl_pkg::engine_sel_t sel_dec;
    cnn_ctrl_pkg::engine_sel_t sel;
    logic                      op_done;

    // Engine decode from the parsed op
    always_comb begin
        sel_dec = '0;
        case (desc.op)
            cnn_cmd_pkg::op_conv1x1,
            cnn_cmd_pkg::op_conv3x3,
            cnn_cmd_pkg::op_conv3x3_pad: sel_dec.conv = 1'b1;
            cnn_cmd_pkg::op_maxpool3:    sel_dec.maxpool = 1'b1;
            cnn_cmd_pkg::op_avepool13:   sel_dec.avepool = 1'b1;
            // Idle and unused codes select nothing
            default:                     sel_dec = '0;
        endcase
    end

    // Only the active engine's valid counts; empty select is done at once
    assign op_done = (sel.conv && conv_valid) ||
                     (sel.maxpool && maxpool_valid) ||
                     (sel.avepool && avepool_valid) ||
                     (sel == '0);

    always_comb begin
        state_nxt = state;
        case (state)
            cnn_ctrl_pkg::st_idle: begin
                if (op_en) begin
                    state_nxt = cnn_ctrl_pkg::st_collect;
                end
            end
            cnn_ctrl_pkg::st_collect: begin
                if (desc_done) begin
                    state_nxt = cnn_ctrl_pkg::st_issue;
                end
            end
            // Single cycle
            cnn_ctrl_pkg::st_issue: state_nxt = cnn_ctrl_pkg::st_wait;
            cnn_ctrl_pkg::st_wait: begin
                if (op_done) begin
                    // More commands queued, fetch the next
                    state_nxt = fifo_empty ? cnn_ctrl_pkg::st_finish : cnn_ctrl_pkg::st_collect;
                end
            end
            cnn_ctrl_pkg::st_finish: begin
                if (op_en) begin
                    state_nxt = cnn_ctrl_pkg::st_collect;
                end
            end
            default: state_nxt = cnn_ctrl_pkg::st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= cnn_ctrl_pkg::st_idle;
            sel   <= '0;
            irq   <= 1'b0;
        end else begin
            state <= state_nxt;
            if (state == cnn_ctrl_pkg::st_issue) begin
                sel <= sel_dec;
            end else if (state == cnn_ctrl_pkg::st_wait && op_done) begin
                sel <= '0;
            end
            // Sticky until the next start
            if (state == cnn_ctrl_pkg::st_wait && op_done && fifo_empty) begin
                irq <= 1'b1;
            end else if ((state == cnn_ctrl_pkg::st_idle || state == cnn_ctrl_pkg::st_finish) &&
                         op_en) begin
                irq <= 1'b0;
            end
        end
    end

    // Addresses and op loaded with the select
    always_ff @(posedge clk) begin
        if (state == cnn_ctrl_pkg::st_issue) begin
            r_addr  <= desc.data_addr;
            w_addr  <= desc.wb_addr;
            wt_addr <= desc.wt_addr;
            op_type <= desc.op;
        end
    end

    assign fetch_req     = (state == cnn_ctrl_pkg::st_collect);
    assign conv_ready    = sel.conv;
    assign maxpool_ready = sel.maxpool;
    assign avepool_ready = sel.avepool;
    // Data port for any engine, weight port for convolution only
    assign data_rd_en    = sel.conv || sel.maxpool || sel.avepool;
    assign weight_rd_en  = sel.conv;

endmodule

//--- src/cnn_ctrl_top.sv
`timescale 1ns/1ps
`include "cnn_ctrl_config.svh"

module cnn_ctrl_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   op_en,
    input  logic                   cmd_wr,
    input  logic [31:0]            cmd_wdata,
    output logic                   cmd_full,
    input  logic                   conv_valid,
    input  logic                   maxpool_valid,
    input  logic                   avepool_valid,
    output logic                   fetch_req,
    output logic                   conv_ready,
    output logic                   maxpool_ready,
    output logic                   avepool_ready,
    output logic                   data_rd_en,
    output logic                   weight_rd_en,
    output logic [`CNN_ADDR_W-1:0] r_addr,
    output logic [`CNN_ADDR_W-1:0] w_addr,
    output logic [`CNN_ADDR_W-1:0] wt_addr,
    output cnn_cmd_pkg::op_e       op_type,
    output logic                   irq
);

    // FIFO to parser
    logic [31:0]              fifo_head;
    logic                     fifo_empty;
    logic                     fifo_rd_en;
    // Parser to dispatcher
    cnn_cmd_pkg::layer_desc_t desc;
    logic                     desc_done;

    cmd_fifo u_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .wr    (cmd_wr),
        .wdata (cmd_wdata),
        .rd_en (fifo_rd_en),
        .head  (fifo_head),
        .empty (fifo_empty),
        .full  (cmd_full)
    );

    cmd_parser u_parser (
        .clk        (clk),
        .rst_n      (rst_n),
        .fetch_req  (fetch_req),
        .fifo_head  (fifo_head),
        .fifo_empty (fifo_empty),
        .fifo_rd_en (fifo_rd_en),
        .desc       (desc),
        .desc_done  (desc_done)
    );

    op_dispatcher u_disp (
        .clk           (clk),
        .rst_n         (rst_n),
        .op_en         (op_en),
        .desc          (desc),
        .desc_done     (desc_done),
        .fifo_empty    (fifo_empty),
        .fetch_req     (fetch_req),
        .conv_valid    (conv_valid),
        .maxpool_valid (maxpool_valid),
        .avepool_valid (avepool_valid),
        .conv_ready    (conv_ready),
        .maxpool_ready (maxpool_ready),
        .avepool_ready (avepool_ready),
        .data_rd_en    (data_rd_en),
        .weight_rd_en  (weight_rd_en),
        .r_addr        (r_addr),
        .w_addr        (w_addr),
        .wt_addr       (wt_addr),
        .op_type       (op_type),
        .irq           (irq)
    );

endmodule

//--- testbench/cnn_ctrl_chk.sv
`timescale 1ns/1ps

module cnn_ctrl_chk (
    input logic             clk,
    input logic             rst_n,
    input logic             conv_ready,
    input logic             maxpool_ready,
    input logic             avepool_ready,
    input logic             conv_valid,
    input logic             maxpool_valid,
    input logic             avepool_valid,
    input logic             data_rd_en,
    input logic             weight_rd_en,
    input cnn_cmd_pkg::op_e op_type,
    input logic             irq
);

    logic [2:0] rdy;
    logic [2:0] vld;
    // Sticky, set by any failing property
    logic       fail_seen = 1'b0;

    assign rdy = {conv_ready, maxpool_ready, avepool_ready};
    assign vld = {conv_valid, maxpool_valid, avepool_valid};

    // Everything quiet in reset and on the first edge after release
    a_reset_quiet: assert property (@(posedge clk) (!rst_n || $rose(rst_n)) |->
        (rdy == 3'b000 && !data_rd_en && !weight_rd_en && !irq))
        else begin
            fail_seen = 1'b1;
            $error("ready, read enable or irq active around reset");
        end

    // Never two engines at once
    a_one_ready: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(rdy))
        else begin
            fail_seen = 1'b1;
            $error("more than one engine ready");
        end

    // Convolution ops, weight port open
    a_conv_sel: assert property (@(posedge clk) disable iff (!rst_n) conv_ready |->
        (weight_rd_en && data_rd_en && (op_type == cnn_cmd_pkg::op_conv1x1 ||
         op_type == cnn_cmd_pkg::op_conv3x3 || op_type == cnn_cmd_pkg::op_conv3x3_pad)))
        else begin
            fail_seen = 1'b1;
            $error("conv_ready with wrong op or enables");
        end

    // Pools read data only
    a_pool_sel: assert property (@(posedge clk) disable iff (!rst_n)
        (maxpool_ready || avepool_ready) |-> (!weight_rd_en && data_rd_en &&
        (maxpool_ready ? op_type == cnn_cmd_pkg::op_maxpool3
                       : op_type == cnn_cmd_pkg::op_avepool13)))
        else begin
            fail_seen = 1'b1;
            $error("pool ready with wrong op or enables");
        end

    // Held until the matching valid, other valids ignored
    a_ready_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (rdy != 3'b000 && (rdy & vld) == 3'b000) |=> rdy == $past(rdy))
        else begin
            fail_seen = 1'b1;
            $error("ready dropped without its valid");
        end

    a_ready_drop: assert property (@(posedge clk) disable iff (!rst_n)
        (rdy & vld) != 3'b000 |=> rdy == 3'b000)
        else begin
            fail_seen = 1'b1;
            $error("ready still high after its valid");
        end

    a_irq_idle: assert property (@(posedge clk) disable iff (!rst_n) irq |-> rdy == 3'b000)
        else begin
            fail_seen = 1'b1;
            $error("irq high while an engine is ready");
        end

endmodule

//--- testbench/cnn_ctrl_tb.sv
`timescale 1ns/1ps

module cnn_ctrl_tb;

    // Commands over both batches
    localparam int N_CMDS  = 11;
    localparam int TIMEOUT = 64 * N_CMDS + 200;

    logic             clk;
    logic             rst_n;
    logic             op_en;
    logic             cmd_wr;
    logic [31:0]      cmd_wdata;
    logic             cmd_full;
    logic             conv_valid, maxpool_valid, avepool_valid;
    logic             fetch_req;
    logic             conv_ready, maxpool_ready, avepool_ready;
    logic             data_rd_en, weight_rd_en;
    logic [31:0]      r_addr, w_addr, wt_addr;
    cnn_cmd_pkg::op_e op_type;
    logic             irq;

    // Descriptors still waiting for their ready, in issue order
    cnn_cmd_pkg::layer_desc_t exp_q[$];
    logic [31:0]              stim_seed;
    logic [31:0]              rsp_seed;
    // High while a batch is still being written
    logic                     feeding;
    logic                     rdy_q;
    logic                     op_en_q;
    int                       cycles = 0;

    cnn_ctrl_top u_dut (.*);

    bind cnn_ctrl_top cnn_ctrl_chk u_chk (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp)
            else stop_run($sformatf("mismatch %s: got %h expected %h", name, got, exp));
    endtask

    // Compare a fresh ready against the oldest queued command
    task automatic check_issue();
        cnn_cmd_pkg::layer_desc_t d;
        logic [4:0]               exp_en;
        assert (exp_q.size() != 0) else stop_run("engine ready with no command outstanding");
        d = exp_q.pop_front();
        // conv, maxpool, avepool, weight, data
        case (int'(d.op))
            1, 2, 3: exp_en = 5'b10011;
            4:       exp_en = 5'b01001;
            5:       exp_en = 5'b00101;
            default: exp_en = 5'b00000;
        endcase
        check_value("r_addr", r_addr, d.data_addr);
        check_value("w_addr", w_addr, d.wb_addr);
        check_value("wt_addr", wt_addr, d.wt_addr);
        check_value("op_type", 32'(op_type), 32'(d.op));
        check_value("engine_sel", 32'({conv_ready, maxpool_ready, avepool_ready,
                                       weight_rd_en, data_rd_en}), 32'(exp_en));
    endtask

    // Six random words, op forced into word 0
    task automatic push_cmd(input logic [2:0] op, input logic split);
        logic [31:0] w [6];
        int          i;
        for (i = 0; i < 6; i++) begin
            stim_seed = lcg_step(stim_seed);
            w[i] = stim_seed;
        end
        w[0][2:0] = op;
        if (op >= 3'd1 && op <= 3'd5) begin
            exp_q.push_back({w[5], w[4], w[3], w[2], w[1], w[0]});
        end
        for (i = 0; i < 6; i++) begin
            @(negedge clk);
            cmd_wr = 1'b0;
            if (split && i == 3) begin
                // Parser drains the FIFO and stalls mid-command
                repeat (12) @(negedge clk);
            end
            while (cmd_full) begin
                @(negedge clk);
            end
            cmd_wr    = 1'b1;
            cmd_wdata = w[i];
        end
        @(negedge clk);
        cmd_wr = 1'b0;
    endtask

    task automatic start_run();
        @(negedge clk);
        op_en = 1'b1;
        @(negedge clk);
        op_en = 1'b0;
    endtask

    task automatic wait_irq();
        while (!irq) begin
            @(negedge clk);
        end
    endtask

    // Engine model, decoy valid from an idle engine first
    initial begin
        int d;
        conv_valid    = 1'b0;
        maxpool_valid = 1'b0;
        avepool_valid = 1'b0;
        rsp_seed      = 32'h641a_161f;
        forever begin
            @(negedge clk);
            if (conv_ready || maxpool_ready || avepool_ready) begin
                rsp_seed = lcg_step(rsp_seed);
                d = int'(rsp_seed[20:18]);
                if (conv_ready) begin
                    maxpool_valid = 1'b1;
                end else begin
                    conv_valid = 1'b1;
                end
                @(negedge clk);
                conv_valid    = 1'b0;
                maxpool_valid = 1'b0;
                repeat (d) @(negedge clk);
                conv_valid    = conv_ready;
                maxpool_valid = maxpool_ready;
                avepool_valid = avepool_ready;
                @(negedge clk);
                conv_valid    = 1'b0;
                maxpool_valid = 1'b0;
                avepool_valid = 1'b0;
            end
        end
    end

    // Outputs sampled on the rising edge, before they update
    always @(posedge clk) begin
        if (!rst_n) begin
            rdy_q   = 1'b0;
            op_en_q = 1'b0;
        end else begin
            if ((conv_ready || maxpool_ready || avepool_ready) && !rdy_q) begin
                check_issue();
            end
            assert (!(irq && (conv_ready || maxpool_ready || avepool_ready || feeding ||
                              exp_q.size() != 0)))
                else stop_run("irq high while a command is still pending");
            assert (!(op_en_q && irq)) else stop_run("irq still high after op_en");
            // No fetch while an engine runs or irq is set
            assert (!(fetch_req && (conv_ready || maxpool_ready || avepool_ready || irq)))
                else stop_run("fetch_req high while an engine is ready or irq is set");
            assert (!u_dut.u_chk.fail_seen) else stop_run("bound protocol assertion failed");
            rdy_q   = conv_ready || maxpool_ready || avepool_ready;
            op_en_q = op_en;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT) begin
            stop_run($sformatf("timeout after %0d cycles", cycles));
        end
    end

    initial begin
        rst_n     = 1'b0;
        op_en     = 1'b0;
        cmd_wr    = 1'b0;
        cmd_wdata = '0;
        feeding   = 1'b0;
        stim_seed = 32'h641a_161f;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        // First batch, two commands waiting before start, unused codes mixed in
        feeding = 1'b1;
        push_cmd(3'd1, 1'b0);
        push_cmd(3'd4, 1'b0);
        start_run();
        push_cmd(3'd0, 1'b0);
        push_cmd(3'd2, 1'b0);
        push_cmd(3'd5, 1'b0);
        push_cmd(3'd6, 1'b0);
        push_cmd(3'd3, 1'b0);
        push_cmd(3'd7, 1'b0);
        feeding = 1'b0;
        wait_irq();
        // Second batch starts on an empty FIFO
        start_run();
        feeding = 1'b1;
        push_cmd(3'd3, 1'b1);
        push_cmd(3'd0, 1'b0);
        push_cmd(3'd5, 1'b0);
        feeding = 1'b0;
        wait_irq();
        if (exp_q.size() == 0) begin
            $display("** PASS **");
            $finish;
        end else begin
            stop_run("commands finished without raising a ready");
        end
    end

endmodule

//--- cnn_ctrl.f
+incdir+src
src/cnn_cmd_pkg.sv
src/cnn_ctrl_pkg.sv
src/cmd_fifo.sv
src/cmd_parser.sv
src/op_dispatcher.sv
src/cnn_ctrl_top.sv
testbench/cnn_ctrl_chk.sv
testbench/cnn_ctrl_tb.sv

//--- Makefile
TOP := cnn_ctrl_tb

.PHONY: run lint clean

run:
	verilator --binary --timing --assert -f cnn_ctrl.f --top-module $(TOP)
	@out=$$(./obj_dir/V$(TOP) +verilator+error+limit+100); \
	echo "$$out"; \
	echo "$$out" | grep -qF '** PASS **'

lint:
	verilator --lint-only --timing --assert -f cnn_ctrl.f --top-module $(TOP)

clean:
	rm -rf obj_dir
